//--- ex_stage.f
+incdir+include
verilog/ex_op_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_mult_if.sv
verilog/ex_issue.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_wb_reg.sv
verilog/ex_stage.sv
verification/ex_stage_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ex_stage_tb
FLIST     := ex_stage.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) verification/ex_patterns.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/ex_patterns.txt
// Columns FUO_RR_AAAAAAAA_BBBBBBBB with F flags (8 jump, 4 branch, 2 kill, 1 illegal),
// U unit (0 ALU, 1 multiplier), O operator, RR destination register, A and B operands
000_01_00000005_00000007 // add
001_02_00000003_00000005 // sub
002_03_f0f0f0f0_ff00ff00 // and
003_04_f0f0f0f0_0f0f0000 // or
004_05_aaaaaaaa_ffff0000 // xor
005_06_80000001_0000001f // sll
006_07_80000000_0000001f // srl
007_08_80000000_0000001f // sra
008_09_ffffffff_00000001 // slt
009_0a_ffffffff_00000001 // sltu
010_0b_00000001_00000002 // mul
011_0c_80000000_80000000 // mulh
012_0d_ffffffff_ffffffff // mulhsu
013_0e_ffffffff_ffffffff // mulhu
40a_00_00001234_00001234 // beq
40b_00_00001234_00001234 // bne
40c_00_ffffffff_00000001 // blt
40d_00_80000000_7fffffff // bge
40e_00_00000001_ffffffff // bltu
40f_00_ffffffff_ffffffff // bgeu
800_01_00001000_00000004 // jal link
200_0f_deadbeef_00000001 // killed add
100_10_00000011_00000022 // illegal add
010_11_7fffffff_7fffffff // mul
011_12_80000000_7fffffff // mulh
012_13_80000000_ffffffff // mulhsu
210_14_00000003_00000004 // killed mul
001_15_00000000_00000001 // sub
007_16_7fffffff_00000004 // sra
013_17_80000000_80000000 // mulhu
000_18_ffffffff_00000001 // add wrap
008_19_7fffffff_80000000 // slt

//--- verification/ex_stage_tb.sv
/* Execute stage testbench with pattern driver, reference model and writeback scoreboard */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb;
  import ex_op_pkg::*;

  typedef logic [`EX_XLEN-1:0] word_t;

  // Expected EX/WB record
  typedef struct packed {
    logic                   rf_we;
    logic [`EX_RADDR_W-1:0] rf_waddr;
    word_t                  rf_wdata;
    word_t                  pc;
    logic                   illegal;
    logic                   jmp;
    logic                   bch;
    logic                   taken;
  } wb_exp_t;

  localparam int NUM_PAT = 32;
  // Worst case per pattern is a multiply plus writeback stalls, reset and drain on top
  localparam int TIMEOUT_CYCLES = NUM_PAT * (`EX_MUL_LAT + `EX_TIMEOUT_MARGIN) * 4 + 20;

  logic clk = 1'b0;
  logic rst_n;
  logic instr_valid_i, alu_en_i, mul_en_i, rf_we_i, alu_jmp_i, alu_bch_i, illegal_insn_i;
  logic [`EX_RADDR_W-1:0] rf_waddr_i;
  alu_op_e alu_op_i;
  mul_op_e mul_op_i;
  word_t operand_a_i, operand_b_i, operand_c_i, pc_i;
  logic kill_i, halt_i, wb_ready_i;
  logic ex_ready_o, ex_valid_o, branch_decision_o;
  word_t branch_target_o, rf_wdata_o;
  logic wb_instr_valid_o, wb_rf_we_o, wb_illegal_o, wb_jmp_o, wb_bch_o, wb_bch_taken_o;
  logic [`EX_RADDR_W-1:0] wb_rf_waddr_o;
  word_t wb_rf_wdata_o, wb_pc_o;

  logic [83:0] pats [0:NUM_PAT-1];
  wb_exp_t exp_q[$];
  logic [31:0] lfsr = 32'hbb3d_6ffb;
  int mismatches = 0;
  int other_errs = 0;
  int checks = 0;
  int cycles = 0;

  ex_stage dut (.*);

  always #4 clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, writeback never drained", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference model

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic cmp_ref(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_EQ:           return a == b;
      ALU_NE:           return a != b;
      ALU_SLT, ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:           return $signed(a) >= $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GEU:          return a >= b;
      default:          return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      // Set-less-than and branches give the compare flag
      default: return word_t'(cmp_ref(op, a, b));
    endcase
  endfunction

  function automatic word_t mul_ref(input mul_op_e op, input word_t a, input word_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    // Operand signs per RISC-V M extension
    wa = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    wb = (op == MUL_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = wa * wb;
    return (op == MUL_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic expect_eq(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic verify_idle(input string when);
    expect_eq({"wb control bits ", when},
              word_t'({wb_instr_valid_o, wb_rf_we_o, wb_jmp_o, wb_bch_o, wb_bch_taken_o}), '0);
  endtask

  // A record leaves EX/WB on an edge with writeback ready
  task automatic check_writeback();
    wb_exp_t e;
    if (wb_instr_valid_o && wb_ready_i) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        other_errs++;
        $display("Error at %0t: unexpected record in writeback, pc %h", $time, wb_pc_o);
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        expect_eq("wb_pc", wb_pc_o, e.pc);
        expect_eq("wb_rf_we", word_t'(wb_rf_we_o), word_t'(e.rf_we));
        expect_eq("wb_rf_waddr", word_t'(wb_rf_waddr_o), word_t'(e.rf_waddr));
        if (!e.illegal) begin
          expect_eq("wb_rf_wdata", wb_rf_wdata_o, e.rf_wdata);
        end
        expect_eq("wb illegal/jmp/bch/taken",
                  word_t'({wb_illegal_o, wb_jmp_o, wb_bch_o, wb_bch_taken_o}),
                  word_t'({e.illegal, e.jmp, e.bch, e.taken}));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic apply_pattern(input int i);
    logic [83:0] p;
    p = pats[i];
    instr_valid_i  = 1'b1;
    alu_jmp_i      = p[83];
    alu_bch_i      = p[82];
    kill_i         = p[81];
    illegal_insn_i = p[80];
    alu_en_i       = (p[79:76] == 4'd0);
    mul_en_i       = (p[79:76] == 4'd1);
    alu_op_i       = alu_op_e'(p[75:72]);
    mul_op_i       = mul_op_e'(p[73:72]);
    rf_waddr_i     = p[68:64];
    operand_a_i    = p[63:32];
    operand_b_i    = p[31:0];
    // Branches write no register
    rf_we_i        = !p[82];
    pc_i           = 32'h0000_1000 + 32'(i) * 4;
    operand_c_i    = pc_i + 32'h100;
  endtask

  task automatic push_expected();
    wb_exp_t e;
    e.rf_we    = rf_we_i && !illegal_insn_i;
    e.rf_waddr = rf_waddr_i;
    e.rf_wdata = mul_en_i ? mul_ref(mul_op_i, operand_a_i, operand_b_i)
                          : alu_ref(alu_op_i, operand_a_i, operand_b_i);
    e.pc       = pc_i;
    e.illegal  = illegal_insn_i;
    e.jmp      = alu_jmp_i && alu_en_i;
    e.bch      = alu_bch_i && alu_en_i;
    e.taken    = e.bch && cmp_ref(alu_op_i, operand_a_i, operand_b_i);
    if (!illegal_insn_i) begin
      expect_eq("rf_wdata forward", rf_wdata_o, e.rf_wdata);
    end
    exp_q.push_back(e);
  endtask

  initial begin
    int   cur;
    int   drain;
    logic accepted;
    logic b1;
    logic b2;
    rst_n = 1'b0;
    {instr_valid_i, alu_en_i, mul_en_i, rf_we_i, alu_jmp_i, alu_bch_i} = '0;
    {illegal_insn_i, kill_i, halt_i} = '0;
    wb_ready_i = 1'b1;
    rf_waddr_i = '0;
    alu_op_i = ALU_ADD;
    mul_op_i = MUL_MUL;
    {operand_a_i, operand_b_i, operand_c_i, pc_i} = '0;
    $readmemh("verification/ex_patterns.txt", pats);

    repeat (10) begin
      @(negedge clk);
      verify_idle("in reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    verify_idle("after reset");

    cur = 0;
    drain = 0;
    accepted = 1'b0;
    while (drain < 4) begin
      @(negedge clk);
      // Writeback stalls a quarter of the cycles
      b1 = lfsr_bit();
      b2 = lfsr_bit();
      wb_ready_i = !(b1 && b2);
      if (accepted) begin
        cur++;
      end
      if (cur < NUM_PAT) begin
        apply_pattern(cur);
      end else begin
        instr_valid_i = 1'b0;
        kill_i = 1'b0;
      end
      #2;
      check_writeback();
      if (instr_valid_i && alu_bch_i) begin
        expect_eq("branch_decision", word_t'(branch_decision_o),
                  word_t'(cmp_ref(alu_op_i, operand_a_i, operand_b_i)));
        expect_eq("branch_target", branch_target_o, operand_c_i);
      end
      // Handshake completes on the coming rising edge
      accepted = instr_valid_i && ex_ready_o;
      // Result is valid when a live instruction leaves, never with nothing presented
      if (accepted || !instr_valid_i) begin
        expect_eq("ex_valid", word_t'(ex_valid_o), word_t'(accepted && !kill_i));
      end
      if (accepted && !kill_i) begin
        push_expected();
      end
      if (cur >= NUM_PAT && exp_q.size() == 0) begin
        drain++;
      end
    end

    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/ex_stage.sv
/* Execute stage top with ALU, multiplier and EX/WB register */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // Instruction from decode
  input  logic                   instr_valid_i,
  input  logic                   alu_en_i,
  input  logic                   mul_en_i,
  input  logic                   rf_we_i,
  input  logic                   alu_jmp_i,
  input  logic                   alu_bch_i,
  input  logic                   illegal_insn_i,
  input  logic [`EX_RADDR_W-1:0] rf_waddr_i,
  input  ex_op_pkg::alu_op_e     alu_op_i,
  input  ex_op_pkg::mul_op_e     mul_op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_XLEN-1:0]    operand_c_i,
  input  logic [`EX_XLEN-1:0]    pc_i,
  // Pipeline control
  input  logic                   kill_i,
  input  logic                   halt_i,
  input  logic                   wb_ready_i,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  // Towards fetch
  output logic                   branch_decision_o,
  output logic [`EX_XLEN-1:0]    branch_target_o,
  // Forwarding to decode
  output logic [`EX_XLEN-1:0]    rf_wdata_o,
  // EX/WB record
  output logic                   wb_instr_valid_o,
  output logic                   wb_rf_we_o,
  output logic [`EX_RADDR_W-1:0] wb_rf_waddr_o,
  output logic [`EX_XLEN-1:0]    wb_rf_wdata_o,
  output logic [`EX_XLEN-1:0]    wb_pc_o,
  output logic                   wb_illegal_o,
  output logic                   wb_jmp_o,
  output logic                   wb_bch_o,
  output logic                   wb_bch_taken_o
);
  import ex_pipe_pkg::*;

  id_ex_t              id_ex;
  ex_wb_t              ex_wb;
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;

  ex_mult_if mul_if (.clk(clk));

  ////////////////////////////////////////////////////////////////////////////
  // Pack decode inputs into one record

  always_comb begin
    id_ex.instr_valid  = instr_valid_i;
    id_ex.alu_en       = alu_en_i;
    id_ex.mul_en       = mul_en_i;
    id_ex.rf_we        = rf_we_i;
    id_ex.alu_jmp      = alu_jmp_i;
    id_ex.alu_bch      = alu_bch_i;
    id_ex.illegal_insn = illegal_insn_i;
    id_ex.rf_waddr     = rf_waddr_i;
    id_ex.alu_op       = alu_op_i;
    id_ex.mul_op       = mul_op_i;
    id_ex.operand_a    = operand_a_i;
    id_ex.operand_b    = operand_b_i;
    id_ex.operand_c    = operand_c_i;
    id_ex.pc           = pc_i;
  end

  // Multiplier shares the ALU operands
  assign mul_if.mul_op = id_ex.mul_op;
  assign mul_if.op_a   = id_ex.operand_a;
  assign mul_if.op_b   = id_ex.operand_b;

  ////////////////////////////////////////////////////////////////////////////
  // Units

  ex_issue u_issue (
    .id_ex_i    (id_ex),
    .kill_i     (kill_i),
    .halt_i     (halt_i),
    .wb_ready_i (wb_ready_i),
    .mul        (mul_if),
    .ex_ready_o (ex_ready_o),
    .ex_valid_o (ex_valid_o)
  );

  ex_alu u_alu (
    .alu_op_i     (id_ex.alu_op),
    .operand_a_i  (id_ex.operand_a),
    .operand_b_i  (id_ex.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .mul   (mul_if)
  );

  ex_wb_reg u_wb_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_i      (id_ex),
    .alu_result_i (alu_result),
    .mul_result_i (mul_if.mul_result),
    .cmp_result_i (alu_cmp),
    .ex_valid_i   (ex_valid_o),
    .wb_ready_i   (wb_ready_i),
    .rf_wdata_o   (rf_wdata_o),
    .ex_wb_o      (ex_wb)
  );

  // Branch resolution goes straight back to fetch
  assign branch_decision_o = alu_cmp;
  assign branch_target_o   = id_ex.operand_c;

  // Unpack the EX/WB record
  assign wb_instr_valid_o = ex_wb.instr_valid;
  assign wb_rf_we_o       = ex_wb.rf_we;
  assign wb_rf_waddr_o    = ex_wb.rf_waddr;
  assign wb_rf_wdata_o    = ex_wb.rf_wdata;
  assign wb_pc_o          = ex_wb.pc;
  assign wb_illegal_o     = ex_wb.illegal_insn;
  assign wb_jmp_o         = ex_wb.jmp_qual;
  assign wb_bch_o         = ex_wb.bch_qual;
  assign wb_bch_taken_o   = ex_wb.bch_taken_qual;

endmodule

//--- verilog/ex_wb_reg.sv
/* Result select and the EX/WB pipeline register */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_wb_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pipe_pkg::id_ex_t id_ex_i,
  input  logic [`EX_XLEN-1:0] alu_result_i,
  input  logic [`EX_XLEN-1:0] mul_result_i,
  input  logic                cmp_result_i,
  input  logic                ex_valid_i,
  input  logic                wb_ready_i,
  output logic [`EX_XLEN-1:0] rf_wdata_o,
  output ex_pipe_pkg::ex_wb_t ex_wb_o
);

  logic transfer;

  // Record moves on when both sides agree
  assign transfer = ex_valid_i && wb_ready_i;

  // Forwarding value
  // Invalid instructions never write so the enables need no gating here
  assign rf_wdata_o = id_ex_i.mul_en ? mul_result_i : alu_result_i;

  // EX/WB record, control bits reset and payload loaded on transfer only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_o.instr_valid    <= 1'b0;
      ex_wb_o.rf_we          <= 1'b0;
      ex_wb_o.illegal_insn   <= 1'b0;
      ex_wb_o.jmp_qual       <= 1'b0;
      ex_wb_o.bch_qual       <= 1'b0;
      ex_wb_o.bch_taken_qual <= 1'b0;
    end else if (transfer) begin
      ex_wb_o.instr_valid    <= 1'b1;
      // Illegal instructions must not update the register file
      ex_wb_o.rf_we          <= id_ex_i.rf_we && !id_ex_i.illegal_insn;
      ex_wb_o.illegal_insn   <= id_ex_i.illegal_insn;
      ex_wb_o.jmp_qual       <= id_ex_i.alu_jmp && id_ex_i.alu_en;
      ex_wb_o.bch_qual       <= id_ex_i.alu_bch && id_ex_i.alu_en;
      ex_wb_o.bch_taken_qual <= id_ex_i.alu_bch && id_ex_i.alu_en && cmp_result_i;
      // Payload
      ex_wb_o.rf_waddr       <= id_ex_i.rf_waddr;
      ex_wb_o.rf_wdata       <= rf_wdata_o;
      ex_wb_o.pc             <= id_ex_i.pc;
    end else if (wb_ready_i) begin
      // WB can take data but EX has none, so a bubble enters
      ex_wb_o.instr_valid    <= 1'b0;
    end
  end

  // Result waiting on writeback keeps its instruction until it is taken
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_i && !wb_ready_i) |=> $stable(id_ex_i))
    else $error("instruction changed while waiting for writeback");

endmodule

//--- verilog/ex_mult.sv
/* Two-stage 32x32 multiplier built from four 16x16 partial products */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_mult (
  input logic     clk,
  input logic     rst_n,
  ex_mult_if.unit mul
);
  import ex_op_pkg::*;

  localparam int XLEN = `EX_XLEN;
  localparam int HALF = XLEN / 2;

  logic                     a_sext;
  logic                     b_sext;
  logic signed [HALF:0]     a_hi;
  logic signed [HALF:0]     a_lo;
  logic signed [HALF:0]     b_hi;
  logic signed [HALF:0]     b_lo;
  logic signed [2*HALF+1:0] pp_ll;
  logic signed [2*HALF+1:0] pp_lh;
  logic signed [2*HALF+1:0] pp_hl;
  logic signed [2*HALF+1:0] pp_hh;
  logic signed [2*XLEN-1:0] prod;
  logic [XLEN-1:0]          result_q;
  logic                     pp_vld;
  logic                     done_q;
  logic                     idle;

  assign idle = !pp_vld && !done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 registers the partial products

  // Operand signedness per operator
  assign a_sext = (mul.mul_op == MUL_MULH) || (mul.mul_op == MUL_MULHSU);
  assign b_sext = (mul.mul_op == MUL_MULH);

  // Upper halves carry the extended sign, lower halves are unsigned
  assign a_hi = {a_sext & mul.op_a[XLEN-1], mul.op_a[XLEN-1:HALF]};
  assign a_lo = {1'b0, mul.op_a[HALF-1:0]};
  assign b_hi = {b_sext & mul.op_b[XLEN-1], mul.op_b[XLEN-1:HALF]};
  assign b_lo = {1'b0, mul.op_b[HALF-1:0]};

  always_ff @(posedge clk) begin
    if (idle && mul.mul_valid) begin
      pp_ll <= a_lo * b_lo;
      pp_lh <= a_lo * b_hi;
      pp_hl <= a_hi * b_lo;
      pp_hh <= a_hi * b_hi;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2 sums and picks the word

  assign prod = pp_ll + (pp_lh <<< HALF) + (pp_hl <<< HALF) + (pp_hh <<< XLEN);

  always_ff @(posedge clk) begin
    if (pp_vld) begin
      result_q <= (mul.mul_op == MUL_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end
  end

  // Sequencing of the two stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_vld <= 1'b0;
      done_q <= 1'b0;
    end else if (!mul.mul_valid) begin
      // Kill or halt aborts the operation
      pp_vld <= 1'b0;
      done_q <= 1'b0;
    end else begin
      pp_vld <= idle;
      if (pp_vld) begin
        done_q <= 1'b1;
      end else if (mul.res_ready) begin
        // Result taken by writeback
        done_q <= 1'b0;
      end
    end
  end

  // Ready when free and not asked, or when the result leaves now
  assign mul.mul_ready  = (idle && !mul.mul_valid) || (done_q && mul.res_ready);
  assign mul.mul_done   = done_q;
  assign mul.mul_result = result_q;

  // Upstream must hold the request while the unit works on it
  a_ops_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!idle && mul.mul_valid) |->
      $stable(mul.op_a) && $stable(mul.op_b) && $stable(mul.mul_op))
    else $error("multiplier operands changed while busy");

  // Uninterrupted request finishes after the fixed latency
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (idle && mul.mul_valid) ##1 mul.mul_valid [*(`EX_MUL_LAT-1)] |=> mul.mul_done)
    else $error("multiplier missed its latency");

endmodule

//--- verilog/ex_alu.sv
/* Single-cycle ALU with shared adder, shared shifter and compare unit */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_alu (
  input  ex_op_pkg::alu_op_e  alu_op_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);
  import ex_op_pkg::*;

  localparam int XLEN = `EX_XLEN;
  localparam int SHW  = $clog2(XLEN);

  logic            is_sub;
  logic            is_signed;
  logic [XLEN:0]   adder_a;
  logic [XLEN:0]   adder_b;
  logic [XLEN:0]   adder_sum;
  logic            lt;
  logic            eq;
  logic [XLEN-1:0] a_rev;
  logic [XLEN-1:0] shift_src;
  logic [XLEN:0]   shift_ext;
  logic [XLEN:0]   shift_res;
  logic [XLEN-1:0] shift_rev;
  logic [XLEN-1:0] shift_out;

  ////////////////////////////////////////////////////////////////////////////
  // Adder and compare

  // Everything but ADD subtracts, compares use the difference
  assign is_sub    = (alu_op_i != ALU_ADD);
  assign is_signed = (alu_op_i inside {ALU_SLT, ALU_LT, ALU_GE});

  // One extra bit so the sign of the difference never overflows
  assign adder_a   = {is_signed & operand_a_i[XLEN-1], operand_a_i};
  assign adder_b   = {is_signed & operand_b_i[XLEN-1], operand_b_i} ^ {(XLEN+1){is_sub}};
  assign adder_sum = adder_a + adder_b + {{XLEN{1'b0}}, is_sub};

  assign lt = adder_sum[XLEN];
  assign eq = (operand_a_i == operand_b_i);

  always_comb begin
    case (alu_op_i)
      ALU_EQ:           cmp_result_o = eq;
      ALU_NE:           cmp_result_o = !eq;
      ALU_GE, ALU_GEU:  cmp_result_o = !lt;
      // Less-than for SLT, SLTU, LT and LTU
      default:          cmp_result_o = lt;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shifter

  // Left shift runs on the right shifter with reversed bits
  assign a_rev     = {<<{operand_a_i}};
  assign shift_src = (alu_op_i == ALU_SLL) ? a_rev : operand_a_i;
  assign shift_ext = {(alu_op_i == ALU_SRA) & operand_a_i[XLEN-1], shift_src};
  assign shift_res = $signed(shift_ext) >>> operand_b_i[SHW-1:0];
  assign shift_rev = {<<{shift_res[XLEN-1:0]}};
  assign shift_out = (alu_op_i == ALU_SLL) ? shift_rev : shift_res[XLEN-1:0];

  // Result select
  always_comb begin
    case (alu_op_i)
      ALU_ADD, ALU_SUB:          result_o = adder_sum[XLEN-1:0];
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_out;
      // Set-less-than and branch compares return the flag
      default:                   result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- verilog/ex_issue.sv
/* Input side of EX with kill/halt gating and the stage ready/valid handshake */
`timescale 1ns/100ps

module ex_issue (
  input  ex_pipe_pkg::id_ex_t id_ex_i,
  input  logic                kill_i,
  input  logic                halt_i,
  input  logic                wb_ready_i,
  ex_mult_if.ctrl             mul,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic instr_valid;
  logic prev_exception;
  logic alu_fin;
  logic mul_fin;

  // Instruction still alive after kill and halt
  assign instr_valid = id_ex_i.instr_valid && !kill_i && !halt_i;

  // Exception flagged upstream passes through EX without any unit
  assign prev_exception = id_ex_i.illegal_insn && id_ex_i.instr_valid;

  // Multiplier only starts on a live and legal request
  // Dropping the request aborts a multiply in flight
  assign mul.mul_valid = id_ex_i.mul_en && !id_ex_i.illegal_insn && instr_valid;

  // Finished result leaves the unit on the same edge it enters WB
  assign mul.res_ready = wb_ready_i;

  // ALU is single cycle so its result is valid at once
  assign alu_fin = id_ex_i.alu_en;
  assign mul_fin = id_ex_i.mul_en && mul.mul_done;

  // Kill frees the stage at once
  // Otherwise wait for the multiplier and writeback unless halted
  assign ex_ready_o = kill_i || (mul.mul_ready && wb_ready_i && !halt_i);

  assign ex_valid_o = (alu_fin || mul_fin || prev_exception) && instr_valid;

  // Kill aborts the multiplier, no stale result is left for the next instruction
  a_kill_aborts_mul: assert property (@(posedge mul.clk)
    kill_i |=> !mul.mul_done)
    else $error("multiplier result survived a kill");

endmodule

//--- verilog/ex_mult_if.sv
/* Request and response bundle between the issue logic and the multiplier */
`timescale 1ns/100ps
`include "ex_defs.svh"

interface ex_mult_if (
  input logic clk
);
  import ex_op_pkg::*;

  // Request, gated by kill and halt
  logic                mul_valid;
  mul_op_e             mul_op;
  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  // Writeback can take the finished result
  logic                res_ready;

  // Response from the unit
  logic                mul_ready;
  logic                mul_done;
  logic [`EX_XLEN-1:0] mul_result;

  // Issue side
  modport ctrl (
    input  clk,
    output mul_valid, mul_op, op_a, op_b, res_ready,
    input  mul_ready, mul_done, mul_result
  );

  // Multiplier side
  modport unit (
    input  mul_valid, mul_op, op_a, op_b, res_ready,
    output mul_ready, mul_done, mul_result
  );

endinterface

//--- verilog/ex_pipe_pkg.sv
/* ID/EX and EX/WB pipeline record types */
`include "ex_defs.svh"

package ex_pipe_pkg;
  import ex_op_pkg::*;

  // Instruction as handed over by decode
  typedef struct packed {
    logic                   instr_valid;
    logic                   alu_en;
    logic                   mul_en;
    logic                   rf_we;
    logic                   alu_jmp;
    logic                   alu_bch;
    // Exception raised before EX
    logic                   illegal_insn;
    logic [`EX_RADDR_W-1:0] rf_waddr;
    alu_op_e                alu_op;
    mul_op_e                mul_op;
    logic [`EX_XLEN-1:0]    operand_a;
    logic [`EX_XLEN-1:0]    operand_b;
    // Branch target
    logic [`EX_XLEN-1:0]    operand_c;
    logic [`EX_XLEN-1:0]    pc;
  } id_ex_t;

  // Registered record towards writeback
  typedef struct packed {
    logic                   instr_valid;
    logic                   rf_we;
    logic [`EX_RADDR_W-1:0] rf_waddr;
    logic [`EX_XLEN-1:0]    rf_wdata;
    logic [`EX_XLEN-1:0]    pc;
    logic                   illegal_insn;
    logic                   jmp_qual;
    logic                   bch_qual;
    logic                   bch_taken_qual;
  } ex_wb_t;

endpackage

//--- verilog/ex_op_pkg.sv
/* Operator encodings for the ALU and the multiplier */
package ex_op_pkg;

  // ALU operators, whole 4-bit space is used
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

endpackage

//--- include/ex_defs.svh
/* Width, latency and margin macros for the execute stage */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data path width
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Cycles from multiplier acceptance to result valid
`define EX_MUL_LAT 2

// Extra cycles per operation allowed before a run is declared hung
`define EX_TIMEOUT_MARGIN 4

`endif
